/* common/ara_settings.svh */
// Build-time sizing of the vector unit, included by every package and module that needs it
`ifndef ARA_SETTINGS_SVH
`define ARA_SETTINGS_SVH

// Lane array geometry
`define ARA_NR_LANES       4
`define ARA_ELEN           32
`define ARA_NR_VREGS       8
`define ARA_ELEMS_PER_LANE 4

// Longest vector the register file can hold
`define ARA_VLMAX (`ARA_NR_LANES * `ARA_ELEMS_PER_LANE)

// Elaboration checks expanded once inside the dispatcher
`define ARA_CHECK_SETTINGS \
  if (`ARA_NR_LANES != 2 ** $clog2(`ARA_NR_LANES)) \
    $error("The lane count must be a power of two"); \
  if (`ARA_ELEMS_PER_LANE != 2 ** $clog2(`ARA_ELEMS_PER_LANE)) \
    $error("The elements per lane must be a power of two"); \
  if (`ARA_VLMAX > 31) \
    $error("The largest vector length must fit the 5-bit length field");

`endif

/* common/ara_isa_pkg.sv */
// Instruction-level types seen by the core on the request and response ports
`default_nettype none

`include "ara_settings.svh"

package ara_isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operand and field types
  ////////////////////////////////////////////////////////////////////////////

  // Vector element type that also carries scalars and results
  typedef logic [`ARA_ELEN-1:0] elen_t;

  // Vector register index
  typedef logic [$clog2(`ARA_NR_VREGS)-1:0] vreg_idx_t;

  // Vector length from 0 up to VLMAX inclusive
  typedef logic [$clog2(`ARA_VLMAX + 1)-1:0] vlen_t;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    // Element-wise vd = vs2 op vs1
    VADD    = 3'd0,
    VAND    = 3'd1,
    VXOR    = 3'd2,
    // Scalar into every active element
    VMV_V_X = 3'd3,
    // Element 0 back to the core
    VMV_X_S = 3'd4,
    // Mask reductions on bit 0 of each element
    VCPOP   = 3'd5,
    VFIRST  = 3'd6
  } vop_e;

endpackage : ara_isa_pkg

`default_nettype wire

/* common/ara_pipe_pkg.sv */
// Internal command types broadcast by the dispatcher to the lanes and the mask unit
`default_nettype none

`include "ara_settings.svh"

package ara_pipe_pkg;

  // Per-lane operation for one issued instruction
  typedef enum logic [2:0] {
    LANE_ADD   = 3'd0,
    LANE_AND   = 3'd1,
    LANE_XOR   = 3'd2,
    LANE_BCAST = 3'd3,
    // Nothing written while lane 0 exposes slot 0 of vs2
    LANE_READ0 = 3'd4,
    // Stream bit 0 of vs2 to the mask unit
    LANE_MASK  = 3'd5
  } lane_op_e;

  // Reduction done by the mask unit
  typedef enum logic {
    MASK_CPOP  = 1'b0,
    MASK_FIRST = 1'b1
  } mask_op_e;

  // Element slot inside one lane
  typedef logic [$clog2(`ARA_ELEMS_PER_LANE)-1:0] beat_t;

endpackage : ara_pipe_pkg

`default_nettype wire

/* logic/ara_dispatcher.sv */
// Front end of the accelerator: takes one instruction, issues it and answers the core
`default_nettype none

`include "ara_settings.svh"

module ara_dispatcher import ara_isa_pkg::*; import ara_pipe_pkg::*; (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // Core request
  input  logic                     acc_req_valid_i,
  output logic                     acc_req_ready_o,
  input  vop_e                     acc_req_op_i,
  input  vreg_idx_t                acc_req_vd_i,
  input  vreg_idx_t                acc_req_vs1_i,
  input  vreg_idx_t                acc_req_vs2_i,
  input  elen_t                    acc_req_scalar_i,
  input  vlen_t                    acc_req_vl_i,
  // Core response
  output logic                     acc_resp_valid_o,
  input  logic                     acc_resp_ready_i,
  output elen_t                    acc_resp_result_o,
  output logic                     acc_resp_error_o,
  // Issue broadcast
  output logic                     issue_valid_o,
  output lane_op_e                 lane_op_o,
  output mask_op_e                 mask_op_o,
  output vreg_idx_t                vd_o,
  output vreg_idx_t                vs1_o,
  output vreg_idx_t                vs2_o,
  output elen_t                    scalar_o,
  output vlen_t                    vl_o,
  // Completions
  input  logic [`ARA_NR_LANES-1:0] lane_done_i,
  input  elen_t                    elem0_i,
  input  elen_t                    mask_result_i,
  input  logic                     mask_result_valid_i
);

  `ARA_CHECK_SETTINGS

  typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT, ST_RESP} state_e;

  state_e                   state_q, state_d;
  logic [`ARA_NR_LANES-1:0] done_q;
  logic                     mask_done_q;
  logic                     vl_ok;
  logic                     all_done;
  lane_op_e                 lane_op_d, lane_op_q;
  mask_op_e                 mask_op_d, mask_op_q;
  vreg_idx_t                vd_q, vs1_q, vs2_q;
  elen_t                    scalar_q, result_q;
  vlen_t                    vl_q;
  logic                     error_q;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  assign vl_ok = (acc_req_vl_i != '0) && (acc_req_vl_i <= vlen_t'(`ARA_VLMAX));

  always_comb begin
    mask_op_d = (acc_req_op_i == VFIRST) ? MASK_FIRST : MASK_CPOP;
    case (acc_req_op_i)
      VADD:    lane_op_d = LANE_ADD;
      VAND:    lane_op_d = LANE_AND;
      VXOR:    lane_op_d = LANE_XOR;
      VMV_V_X: lane_op_d = LANE_BCAST;
      VMV_X_S: lane_op_d = LANE_READ0;
      default: lane_op_d = LANE_MASK;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////////////////////

  // Sticky flags plus whatever completes this cycle
  assign all_done = (&(done_q | lane_done_i)) &&
                    ((lane_op_q != LANE_MASK) || mask_done_q || mask_result_valid_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (acc_req_valid_i) state_d = vl_ok ? ST_ISSUE : ST_RESP;
      ST_ISSUE: state_d = ST_WAIT;
      ST_WAIT:  if (all_done) state_d = ST_RESP;
      default:  if (acc_resp_ready_i) state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= ST_IDLE;
      done_q      <= '0;
      mask_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_ISSUE) begin
        done_q      <= '0;
        mask_done_q <= 1'b0;
      end else if (state_q == ST_WAIT) begin
        done_q <= done_q | lane_done_i;
        if (mask_result_valid_i) mask_done_q <= 1'b1;
      end
    end
  end

  // Instruction fields and response payload
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && acc_req_valid_i) begin
      lane_op_q <= lane_op_d;
      mask_op_q <= mask_op_d;
      vd_q      <= acc_req_vd_i;
      vs1_q     <= acc_req_vs1_i;
      vs2_q     <= acc_req_vs2_i;
      scalar_q  <= acc_req_scalar_i;
      vl_q      <= acc_req_vl_i;
      result_q  <= '0;
      error_q   <= ~vl_ok;
    end else if (state_q == ST_WAIT) begin
      // Lane 0 presents element 0 together with its done pulse
      if (lane_op_q == LANE_READ0 && lane_done_i[0]) result_q <= elem0_i;
      if (mask_result_valid_i) result_q <= mask_result_i;
    end
  end

  assign acc_req_ready_o   = (state_q == ST_IDLE);
  assign acc_resp_valid_o  = (state_q == ST_RESP);
  assign acc_resp_result_o = result_q;
  assign acc_resp_error_o  = error_q;

  assign issue_valid_o = (state_q == ST_ISSUE);
  assign lane_op_o     = lane_op_q;
  assign mask_op_o     = mask_op_q;
  assign vd_o          = vd_q;
  assign vs1_o         = vs1_q;
  assign vs2_o         = vs2_q;
  assign scalar_o      = scalar_q;
  assign vl_o          = vl_q;

endmodule : ara_dispatcher

`default_nettype wire

/* lane/lane.sv */
// One vector lane with its register slice, element ALU and mask-bit stream
`default_nettype none

`include "ara_settings.svh"

module lane import ara_isa_pkg::*; import ara_pipe_pkg::*; #(
  parameter int unsigned lane_idx = 0
) (
  input  logic      clk_i,
  input  logic      reset_i,
  // Issue broadcast
  input  logic      issue_valid_i,
  input  lane_op_e  lane_op_i,
  input  vreg_idx_t vd_i,
  input  vreg_idx_t vs1_i,
  input  vreg_idx_t vs2_i,
  input  elen_t     scalar_i,
  input  vlen_t     vl_i,
  // Completion
  output logic      done_o,
  output elen_t     elem0_o,
  // Mask stream
  output logic      mask_bit_o,
  output logic      mask_valid_o,
  output logic      mask_last_o
);

  localparam int unsigned cnt_width = $clog2(`ARA_ELEMS_PER_LANE + 1);

  // Slot s holds element s * lanes + lane_idx
  elen_t                vrf_q [`ARA_NR_VREGS][`ARA_ELEMS_PER_LANE];

  logic                 busy_q, empty_q;
  beat_t                beat_q, last_beat_q;
  lane_op_e             op_q;
  vreg_idx_t            vd_q, vs1_q, vs2_q;
  elen_t                scalar_q;
  logic [cnt_width-1:0] active_cnt;
  elen_t                op_a, op_b, alu_res;
  logic                 last_beat, writes;

  // Number of elements below vl that live in this lane
  always_comb begin
    active_cnt = '0;
    if (vl_i > lane_idx)
      active_cnt = cnt_width'((vl_i - lane_idx - 1) / `ARA_NR_LANES + 1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Beat sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q  <= 1'b0;
      empty_q <= 1'b0;
      beat_q  <= '0;
    end else if (issue_valid_i) begin
      busy_q  <= (active_cnt != '0);
      empty_q <= (active_cnt == '0);
      beat_q  <= '0;
    end else begin
      empty_q <= 1'b0;
      if (busy_q) begin
        if (last_beat) busy_q <= 1'b0;
        beat_q <= beat_t'(beat_q + 1'b1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      op_q        <= lane_op_i;
      vd_q        <= vd_i;
      vs1_q       <= vs1_i;
      vs2_q       <= vs2_i;
      scalar_q    <= scalar_i;
      last_beat_q <= beat_t'(active_cnt - 1'b1);
    end
  end

  assign last_beat = busy_q && (beat_q == last_beat_q);

  ////////////////////////////////////////////////////////////////////////////
  // Element ALU and register slice
  ////////////////////////////////////////////////////////////////////////////

  assign op_a = vrf_q[vs1_q][beat_q];
  assign op_b = vrf_q[vs2_q][beat_q];

  always_comb begin
    writes = 1'b1;
    case (op_q)
      LANE_ADD:   alu_res = op_b + op_a;
      LANE_AND:   alu_res = op_b & op_a;
      LANE_XOR:   alu_res = op_b ^ op_a;
      LANE_BCAST: alu_res = scalar_q;
      default: begin
        alu_res = '0;
        writes  = 1'b0;
      end
    endcase
  end

  // Slots past vl are never visited, so the tail keeps its value
  always_ff @(posedge clk_i) begin
    if (busy_q && writes) vrf_q[vd_q][beat_q] <= alu_res;
  end

  assign done_o  = empty_q || last_beat;
  assign elem0_o = vrf_q[vs2_q][0];

  // Lane 0 holds the most elements, so its last beat ends the stream
  assign mask_valid_o = busy_q && (op_q == LANE_MASK);
  assign mask_bit_o   = op_b[0];
  assign mask_last_o  = (lane_idx == 0) && mask_valid_o && last_beat;

endmodule : lane

`default_nettype wire

/* masku/masku.sv */
// Mask unit reducing the bit streams of all lanes to a population count or first index
`default_nettype none

`include "ara_settings.svh"

module masku import ara_isa_pkg::*; import ara_pipe_pkg::*; (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     issue_valid_i,
  input  mask_op_e                 mask_op_i,
  // From the lanes
  input  logic [`ARA_NR_LANES-1:0] mask_bits_i,
  input  logic [`ARA_NR_LANES-1:0] mask_valid_i,
  input  logic                     mask_last_i,
  // To the dispatcher
  output elen_t                    mask_result_o,
  output logic                     mask_result_valid_o
);

  mask_op_e op_q;
  beat_t    beat_q;
  elen_t    count_q, first_q;
  logic     found_q, last_q;
  elen_t    beat_count, beat_first;
  logic     beat_found;

  // Count the set bits of this beat and locate the lowest lane with one
  always_comb begin
    beat_count = '0;
    beat_first = '0;
    beat_found = 1'b0;
    for (int i = `ARA_NR_LANES - 1; i >= 0; i--) begin
      if (mask_valid_i[i] && mask_bits_i[i]) begin
        beat_count = beat_count + 1'b1;
        beat_first = elen_t'(beat_q) * `ARA_NR_LANES + elen_t'(i);
        beat_found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      op_q    <= MASK_CPOP;
      beat_q  <= '0;
      count_q <= '0;
      found_q <= 1'b0;
      last_q  <= 1'b0;
    end else if (issue_valid_i) begin
      op_q    <= mask_op_i;
      beat_q  <= '0;
      count_q <= '0;
      found_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      last_q <= mask_last_i;
      if (|mask_valid_i) begin
        beat_q  <= beat_t'(beat_q + 1'b1);
        count_q <= count_q + beat_count;
        if (beat_found) found_q <= 1'b1;
      end
    end
  end

  // Earlier beats carry lower indices so only the first hit is kept
  always_ff @(posedge clk_i) begin
    if (!issue_valid_i && !found_q && beat_found) first_q <= beat_first;
  end

  assign mask_result_valid_o = last_q;
  assign mask_result_o       = (op_q == MASK_CPOP) ? count_q :
                               found_q             ? first_q : '1;

endmodule : masku

`default_nettype wire

/* logic/ara_top.sv */
// Accelerator top level tying the dispatcher to the lane array and the mask unit
`default_nettype none

`include "ara_settings.svh"

module ara_top import ara_isa_pkg::*; import ara_pipe_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // Core request
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  input  vop_e      acc_req_op_i,
  input  vreg_idx_t acc_req_vd_i,
  input  vreg_idx_t acc_req_vs1_i,
  input  vreg_idx_t acc_req_vs2_i,
  input  elen_t     acc_req_scalar_i,
  input  vlen_t     acc_req_vl_i,
  // Core response
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i,
  output elen_t     acc_resp_result_o,
  output logic      acc_resp_error_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Issue broadcast and completions
  ////////////////////////////////////////////////////////////////////////////

  logic                     issue_valid;
  lane_op_e                 lane_op;
  mask_op_e                 mask_op;
  vreg_idx_t                vd, vs1, vs2;
  elen_t                    scalar;
  vlen_t                    vl;
  logic [`ARA_NR_LANES-1:0] lane_done;
  elen_t                    lane_elem0 [`ARA_NR_LANES];
  logic [`ARA_NR_LANES-1:0] mask_bits, mask_valid, mask_last;
  elen_t                    mask_result;
  logic                     mask_result_valid;

  ara_dispatcher dispatcher_inst (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .acc_req_valid_i     (acc_req_valid_i),
    .acc_req_ready_o     (acc_req_ready_o),
    .acc_req_op_i        (acc_req_op_i),
    .acc_req_vd_i        (acc_req_vd_i),
    .acc_req_vs1_i       (acc_req_vs1_i),
    .acc_req_vs2_i       (acc_req_vs2_i),
    .acc_req_scalar_i    (acc_req_scalar_i),
    .acc_req_vl_i        (acc_req_vl_i),
    .acc_resp_valid_o    (acc_resp_valid_o),
    .acc_resp_ready_i    (acc_resp_ready_i),
    .acc_resp_result_o   (acc_resp_result_o),
    .acc_resp_error_o    (acc_resp_error_o),
    .issue_valid_o       (issue_valid),
    .lane_op_o           (lane_op),
    .mask_op_o           (mask_op),
    .vd_o                (vd),
    .vs1_o               (vs1),
    .vs2_o               (vs2),
    .scalar_o            (scalar),
    .vl_o                (vl),
    .lane_done_i         (lane_done),
    .elem0_i             (lane_elem0[0]),
    .mask_result_i       (mask_result),
    .mask_result_valid_i (mask_result_valid)
  );

  for (genvar i = 0; i < `ARA_NR_LANES; i++) begin : gen_lanes
    lane #(
      .lane_idx (i)
    ) lane_inst (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .issue_valid_i (issue_valid),
      .lane_op_i     (lane_op),
      .vd_i          (vd),
      .vs1_i         (vs1),
      .vs2_i         (vs2),
      .scalar_i      (scalar),
      .vl_i          (vl),
      .done_o        (lane_done[i]),
      .elem0_o       (lane_elem0[i]),
      .mask_bit_o    (mask_bits[i]),
      .mask_valid_o  (mask_valid[i]),
      .mask_last_o   (mask_last[i])
    );
  end : gen_lanes

  // Only lane 0 ever raises its last flag
  masku masku_inst (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .issue_valid_i       (issue_valid),
    .mask_op_i           (mask_op),
    .mask_bits_i         (mask_bits),
    .mask_valid_i        (mask_valid),
    .mask_last_i         (|mask_last),
    .mask_result_o       (mask_result),
    .mask_result_valid_o (mask_result_valid)
  );

endmodule : ara_top

`default_nettype wire

/* testbench/ara_props.sv */
// Handshake assertions on the accelerator response port, attached to ara_top by bind
`default_nettype none

module ara_props import ara_isa_pkg::*; (
  input logic  clk_i,
  input logic  reset_i,
  input logic  req_valid_i,
  input logic  req_ready_i,
  input logic  resp_valid_i,
  input logic  resp_ready_i,
  input elen_t resp_result_i,
  input logic  resp_error_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic in_flight_q;

  // Set by an accepted request and cleared by the response handshake
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_flight_q <= 1'b0;
    end else if (req_valid_i && req_ready_i) begin
      in_flight_q <= 1'b1;
    end else if (resp_valid_i && resp_ready_i) begin
      in_flight_q <= 1'b0;
    end
  end

  // A pending response holds its payload until the core takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_i && !resp_ready_i |=>
      resp_valid_i && $stable(resp_result_i) && $stable(resp_error_i))
    else $error("Response dropped or changed before the core accepted it");

  // Only one instruction in flight
  assert property (@(posedge clk_i) disable iff (reset_i)
    in_flight_q |-> !req_ready_i)
    else $error("Request port ready while an instruction is in flight");

  assert property (@(posedge clk_i)
    reset_i |=> !resp_valid_i && req_ready_i)
    else $error("Accelerator not idle after reset");

endmodule : ara_props

bind ara_top ara_props props_inst (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .req_valid_i   (acc_req_valid_i),
  .req_ready_i   (acc_req_ready_o),
  .resp_valid_i  (acc_resp_valid_o),
  .resp_ready_i  (acc_resp_ready_i),
  .resp_result_i (acc_resp_result_o),
  .resp_error_i  (acc_resp_error_o)
);

`default_nettype wire

/* testbench/ara_tb.sv */
// Directed testbench for the vector accelerator, simulation top compiled through vlog.f
`default_nettype none

`include "ara_settings.svh"

module ara_tb import ara_isa_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period      = 40;
  localparam int reset_cycles    = 5;
  localparam int num_tests       = 6;
  localparam int cycles_per_test = 200;
  localparam int handshake_limit = 100;

  logic      clk, reset;
  logic      req_valid, req_ready;
  vop_e      req_op;
  vreg_idx_t req_vd, req_vs1, req_vs2;
  elen_t     req_scalar;
  vlen_t     req_vl;
  logic      resp_valid, resp_ready, resp_error;
  elen_t     resp_result;

  integer    seed = 32'hc4c2;
  int        checks, errors, failed_tests;
  string     current_test;
  // Operands shared by the arithmetic, error and back-pressure tests
  elen_t     scalar_a, scalar_b;

  ara_top ara_top_inst (
    .clk_i             (clk),
    .reset_i           (reset),
    .acc_req_valid_i   (req_valid),
    .acc_req_ready_o   (req_ready),
    .acc_req_op_i      (req_op),
    .acc_req_vd_i      (req_vd),
    .acc_req_vs1_i     (req_vs1),
    .acc_req_vs2_i     (req_vs2),
    .acc_req_scalar_i  (req_scalar),
    .acc_req_vl_i      (req_vl),
    .acc_resp_valid_o  (resp_valid),
    .acc_resp_ready_i  (resp_ready),
    .acc_resp_result_o (resp_result),
    .acc_resp_error_o  (resp_error)
  );

  always #(clk_period / 2) clk = ~clk;

  // Watchdog
  initial begin
    #(num_tests * cycles_per_test * clk_period);
    $display("Simulation timed out before all tests finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_elen(input string what, input elen_t expected, input elen_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: %s expected %h actual %h", current_test, what, expected, actual);
    end
  endtask

  task automatic compare_flag(input string what, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: %s expected %b actual %b", current_test, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Test %s: %s", current_test, what);
  endtask

  task automatic finish_test(input int start_errors);
    if (errors == start_errors) begin
      $display("Test %s passed", current_test);
    end else begin
      failed_tests++;
      $display("Test %s failed with %0d errors", current_test, errors - start_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Request and response handshake
  ////////////////////////////////////////////////////////////////////////////

  // Latency counts falling edges from acceptance until the response shows up
  task automatic send_request(input vop_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
                              input vreg_idx_t vs2, input elen_t scalar, input vlen_t vl,
                              input int stall_cycles, output elen_t result,
                              output logic error, output int latency);
    int    waited;
    elen_t held_result;
    logic  held_error;
    result  = '0;
    error   = 1'b1;
    latency = -1;
    @(negedge clk);
    req_valid  = 1'b1;
    req_op     = op;
    req_vd     = vd;
    req_vs1    = vs1;
    req_vs2    = vs2;
    req_scalar = scalar;
    req_vl     = vl;
    waited     = 0;
    while (!req_ready && waited < handshake_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready) begin
      req_valid = 1'b0;
      report_failure("the request was never accepted");
      return;
    end
    @(negedge clk);
    req_valid = 1'b0;
    waited    = 0;
    while (!resp_valid && waited < handshake_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!resp_valid) begin
      report_failure("no response arrived for an accepted request");
      return;
    end
    latency     = waited;
    held_result = resp_result;
    held_error  = resp_error;
    // Core not ready yet
    for (int i = 0; i < stall_cycles; i++) begin
      @(negedge clk);
      if (!resp_valid || resp_result !== held_result || resp_error !== held_error)
        report_failure("the response changed while the core stalled");
      if (req_ready)
        report_failure("a new request could be accepted during the stall");
    end
    result     = resp_result;
    error      = resp_error;
    resp_ready = 1'b1;
    @(negedge clk);
    resp_ready = 1'b0;
    if (!req_ready)
      report_failure("the request port did not return to ready after the response");
  endtask

  // Instructions that write registers answer with a zero result
  task automatic issue_op(input vop_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
                          input vreg_idx_t vs2, input elen_t scalar, input vlen_t vl);
    elen_t result;
    logic  error;
    int    latency;
    send_request(op, vd, vs1, vs2, scalar, vl, 0, result, error, latency);
    compare_flag({op.name(), " error flag"}, 1'b0, error);
    compare_elen({op.name(), " result"}, '0, result);
  endtask

  task automatic check_result(input vop_e op, input vreg_idx_t vs2, input vlen_t vl,
                              input elen_t expected, input string what);
    elen_t result;
    logic  error;
    int    latency;
    send_request(op, '0, '0, vs2, '0, vl, 0, result, error, latency);
    compare_flag({what, " error flag"}, 1'b0, error);
    compare_elen(what, expected, result);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_broadcast_move();
    int    start_errors;
    elen_t value;
    current_test = "broadcast_move";
    start_errors = errors;
    value        = $random(seed);
    issue_op(VMV_V_X, 1, 0, 0, value, `ARA_VLMAX);
    check_result(VMV_X_S, 1, 1, value, "element 0 of v1");
    finish_test(start_errors);
  endtask

  task automatic test_arithmetic();
    int start_errors;
    current_test = "arithmetic";
    start_errors = errors;
    scalar_a     = $random(seed);
    scalar_b     = $random(seed);
    issue_op(VMV_V_X, 2, 0, 0, scalar_a, `ARA_VLMAX);
    issue_op(VMV_V_X, 3, 0, 0, scalar_b, `ARA_VLMAX);
    issue_op(VADD, 4, 3, 2, '0, `ARA_VLMAX);
    issue_op(VAND, 5, 3, 2, '0, `ARA_VLMAX);
    issue_op(VXOR, 6, 3, 2, '0, `ARA_VLMAX);
    check_result(VMV_X_S, 4, 1, scalar_a + scalar_b, "vadd element 0");
    check_result(VMV_X_S, 5, 1, scalar_a & scalar_b, "vand element 0");
    check_result(VMV_X_S, 6, 1, scalar_a ^ scalar_b, "vxor element 0");
    finish_test(start_errors);
  endtask

  // v7 starts with five zero elements followed by ones
  task automatic test_tail_vcpop();
    int start_errors;
    current_test = "tail_vcpop";
    start_errors = errors;
    issue_op(VMV_V_X, 7, 0, 0, 1, `ARA_VLMAX);
    issue_op(VMV_V_X, 7, 0, 0, 0, 5);
    check_result(VCPOP, 7, `ARA_VLMAX, `ARA_VLMAX - 5, "vcpop of the full register");
    check_result(VCPOP, 7, 3, 0, "vcpop of the cleared head");
    finish_test(start_errors);
  endtask

  task automatic test_vfirst();
    int start_errors;
    current_test = "vfirst";
    start_errors = errors;
    check_result(VFIRST, 7, `ARA_VLMAX, 5, "vfirst after the cleared head");
    issue_op(VMV_V_X, 0, 0, 0, 0, `ARA_VLMAX);
    check_result(VFIRST, 0, `ARA_VLMAX, '1, "vfirst of an all-zero register");
    finish_test(start_errors);
  endtask

  task automatic test_length_errors();
    int    start_errors;
    elen_t result;
    logic  error;
    int    latency;
    current_test = "length_errors";
    start_errors = errors;
    send_request(VMV_V_X, 4, 0, 0, $random(seed), 0, 0, result, error, latency);
    compare_flag("vl 0 error flag", 1'b1, error);
    compare_elen("vl 0 result", '0, result);
    compare_flag("vl 0 answered without issue", 1'b1, latency == 0);
    send_request(VMV_V_X, 4, 0, 0, $random(seed), `ARA_VLMAX + 1, 0, result, error, latency);
    compare_flag("vl above maximum error flag", 1'b1, error);
    compare_elen("vl above maximum result", '0, result);
    compare_flag("vl above maximum answered without issue", 1'b1, latency == 0);
    check_result(VMV_X_S, 4, 1, scalar_a + scalar_b, "v4 after rejected writes");
    finish_test(start_errors);
  endtask

  task automatic test_back_pressure();
    int    start_errors;
    int    stall;
    elen_t result;
    logic  error;
    int    latency;
    current_test = "back_pressure";
    start_errors = errors;
    stall        = 1 + ({$random(seed)} % 20);
    send_request(VMV_X_S, 0, 0, 6, '0, 1, stall, result, error, latency);
    compare_flag("stalled vxor read error flag", 1'b0, error);
    compare_elen("stalled vxor read", scalar_a ^ scalar_b, result);
    stall = 1 + ({$random(seed)} % 20);
    send_request(VMV_X_S, 0, 0, 4, '0, 1, stall, result, error, latency);
    compare_flag("stalled vadd read error flag", 1'b0, error);
    compare_elen("stalled vadd read", scalar_a + scalar_b, result);
    finish_test(start_errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    req_valid    = 1'b0;
    req_op       = VADD;
    req_vd       = '0;
    req_vs1      = '0;
    req_vs2      = '0;
    req_scalar   = '0;
    req_vl       = '0;
    resp_ready   = 1'b0;
    checks       = 0;
    errors       = 0;
    failed_tests = 0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_broadcast_move();
    test_arithmetic();
    test_tail_vcpop();
    test_vfirst();
    test_length_errors();
    test_back_pressure();

    $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
             num_tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : ara_tb

`default_nettype wire

/* vlog.f */
+incdir+common
common/ara_isa_pkg.sv
common/ara_pipe_pkg.sv
logic/ara_dispatcher.sv
lane/lane.sv
masku/masku.sv
logic/ara_top.sv
testbench/ara_props.sv
testbench/ara_tb.sv

/* Makefile */
# Verilator build and run of the vector accelerator testbench

SOURCES := $(filter-out +%,$(shell cat vlog.f)) common/ara_settings.svh

.PHONY: run clean

run: obj_dir/Vara_tb
	@out="$$(./obj_dir/Vara_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

obj_dir/Vara_tb: vlog.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
	  --top-module ara_tb -f vlog.f -Mdir obj_dir -o Vara_tb

clean:
	rm -rf obj_dir
